// ==== hdl/mc_rd_pkg.sv ====
package mc_rd_pkg;

    ////////////////////////////////////////
    // sizes
    ////////////////////////////////////////
    localparam int NUM_CH     = 4;  // read channels
    localparam int ADDR_W     = 30; // word address
    localparam int LEN_W      = 8;  // burst length, words minus one
    localparam int DATA_W     = 32; // memory and fifo word
    localparam int FIFO_DEPTH = 64; // words per channel fifo
    localparam int CNT_W      = 7;  // fifo fill count, 0..FIFO_DEPTH
    localparam int CH_W       = 2;  // channel index

    ////////////////////////////////////////
    // bundles
    ////////////////////////////////////////
    typedef struct packed {
        logic [ADDR_W-1:0] beg_addr;  // first word of the range
        logic [ADDR_W-1:0] end_addr;  // last word, inclusive
        logic [LEN_W-1:0]  burst_len; // words per burst minus one
    } ch_cfg_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr; // first word of burst
        logic [LEN_W-1:0]  len;  // words minus one
    } burst_t;

    typedef struct packed {
        logic              en;   // read request valid
        logic [ADDR_W-1:0] addr; // word address
    } mem_req_t;

    typedef struct packed {
        logic              valid; // beat present
        logic [DATA_W-1:0] data;  // returned word
    } fill_t;

    // fsm encodings
    typedef enum logic [1:0] {ARB_IDLE, ARB_START, ARB_BUSY, ARB_RELEASE} arb_state_e;
    typedef enum logic [1:0] {RDR_IDLE, RDR_ISSUE, RDR_DRAIN} rdr_state_e;

endpackage

// ==== hdl/chan_fifo.sv ====
`timescale 1ns/100ps

module chan_fifo (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wr_en,    // push one word
    input  logic [mc_rd_pkg::DATA_W-1:0]  wr_data,
    input  logic                          rd_en,    // pop request
    output logic [mc_rd_pkg::DATA_W-1:0]  rd_data,  // head word, show-ahead
    output logic                          rd_valid, // fifo not empty
    output logic [mc_rd_pkg::CNT_W-1:0]   count     // words held
);
    import mc_rd_pkg::*;

    logic [DATA_W-1:0] mem [FIFO_DEPTH]; // storage ring
    logic [CNT_W-2:0]  wr_ptr;           // wraps at FIFO_DEPTH
    logic [CNT_W-2:0]  rd_ptr;
    logic              pop;              // qualified pop

    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];       // head always visible
    assign pop      = rd_en && rd_valid; // pop on empty ignored

    // storage write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, pop})
                2'b10:   count <= count + 1'b1; // push only
                2'b01:   count <= count - 1'b1; // pop only
                default: count <= count;        // both or neither
            endcase
        end
    end

endmodule

// ==== hdl/rd_channel.sv ====
`timescale 1ns/100ps

module rd_channel (
    input  logic                          clk,
    input  logic                          rst_n,
    input  mc_rd_pkg::ch_cfg_t            cfg,       // range and burst size
    input  logic                          rd_en,     // user pop
    output logic [mc_rd_pkg::DATA_W-1:0]  rd_data,
    output logic                          rd_valid,
    output logic                          req,       // burst request to arbiter
    output mc_rd_pkg::burst_t             burst,     // held while req high
    input  logic                          ack,       // burst fully in fifo
    input  logic                          fill_en,   // beat for this channel
    input  logic [mc_rd_pkg::DATA_W-1:0]  fill_data
);
    import mc_rd_pkg::*;

    logic [ADDR_W-1:0] off;       // words walked since beg_addr
    logic [ADDR_W-1:0] addr;      // next burst start
    logic [ADDR_W-1:0] remain;    // words left up to end_addr, minus one
    logic [ADDR_W-1:0] last_addr; // final word of next burst
    logic [LEN_W-1:0]  len;       // sized burst, minus one
    logic [CNT_W-1:0]  count;     // fifo occupancy
    logic [LEN_W:0]    space;     // free fifo words
    logic [LEN_W:0]    need;      // words in next burst
    logic              room;

    ////////////////////////////////////////
    // address walker and burst sizing
    ////////////////////////////////////////
    assign addr      = cfg.beg_addr + off;
    assign remain    = cfg.end_addr - addr;
    assign len       = (remain < ADDR_W'(cfg.burst_len)) ? remain[LEN_W-1:0]
                                                         : cfg.burst_len; // cut at end_addr
    assign last_addr = addr + ADDR_W'(len);

    assign space = (LEN_W+1)'(FIFO_DEPTH) - (LEN_W+1)'(count);
    assign need  = (LEN_W+1)'(len) + 1'b1;
    assign room  = (space >= need); // whole burst fits

    // off only moves on ack, so burst stays put during req
    assign burst.addr = addr;
    assign burst.len  = len;

    ////////////////////////////////////////
    // four-phase request side
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req <= 1'b0;
            off <= '0;
        end else if (!req) begin
            if (!ack && room) begin // previous ack gone low
                req <= 1'b1;
            end
        end else if (ack) begin
            req <= 1'b0; // falling half
            if (last_addr >= cfg.end_addr) begin
                off <= '0; // wrap to beg_addr
            end else begin
                off <= off + ADDR_W'(len) + 1'b1;
            end
        end
    end

    chan_fifo u_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (fill_en),
        .wr_data  (fill_data),
        .rd_en    (rd_en),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .count    (count)
    );

endmodule

// ==== hdl/rd_arbiter.sv ====
`timescale 1ns/100ps

module rd_arbiter (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [mc_rd_pkg::NUM_CH-1:0]  req,
    input  mc_rd_pkg::burst_t             burst [mc_rd_pkg::NUM_CH],
    output logic [mc_rd_pkg::NUM_CH-1:0]  ack,
    output logic                          start,     // one cycle to reader
    output mc_rd_pkg::burst_t             sel_burst, // granted burst
    input  logic                          done,      // last beat returned
    input  mc_rd_pkg::fill_t              fill,      // beat from reader
    output logic [mc_rd_pkg::NUM_CH-1:0]  fill_en,   // owner write strobe
    output logic [mc_rd_pkg::DATA_W-1:0]  fill_data
);
    import mc_rd_pkg::*;

    arb_state_e       state;
    logic [CH_W-1:0]  owner; // current grant, also last granted
    logic [CH_W-1:0]  pick;  // round-robin winner

    ////////////////////////////////////////
    // round-robin search after owner
    ////////////////////////////////////////
    always_comb begin : rr_search
        logic [CH_W-1:0] idx;
        logic            found;
        pick  = owner;
        found = 1'b0;
        for (int k = 1; k <= NUM_CH; k++) begin
            idx = CH_W'((int'(owner) + k) % NUM_CH);
            if (!found && req[idx]) begin
                pick  = idx;
                found = 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // grant and acknowledge fsm
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ARB_IDLE;
            owner <= CH_W'(NUM_CH - 1); // channel 0 searched first
            ack   <= '0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (|req) begin
                        owner <= pick;
                        state <= ARB_START;
                    end
                end
                ARB_START: state <= ARB_BUSY; // start pulse here
                ARB_BUSY: begin
                    if (done) begin
                        ack[owner] <= 1'b1; // burst fully written
                        state      <= ARB_RELEASE;
                    end
                end
                ARB_RELEASE: begin
                    if (!req[owner]) begin
                        ack   <= '0;
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    assign start     = (state == ARB_START);
    assign sel_burst = burst[owner]; // channel holds it until ack

    // beat steering, owner only
    always_comb begin
        for (int i = 0; i < NUM_CH; i++) begin
            fill_en[i] = fill.valid && (state == ARB_BUSY) && (owner == CH_W'(i));
        end
    end

    assign fill_data = fill.data;

endmodule

// ==== hdl/burst_reader.sv ====
`timescale 1ns/100ps

module burst_reader (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,      // new burst
    input  mc_rd_pkg::burst_t             burst,
    output logic                          done,       // one cycle after last beat
    output mc_rd_pkg::mem_req_t           mem_req,
    input  logic                          mem_ready,  // accept this cycle
    input  logic [mc_rd_pkg::DATA_W-1:0]  mem_rdata,
    input  logic                          mem_rvalid, // one cycle after accept
    output mc_rd_pkg::fill_t              fill
);
    import mc_rd_pkg::*;

    rdr_state_e        state;
    logic [ADDR_W-1:0] cur_addr;  // next address to issue
    logic [LEN_W-1:0]  len_q;     // latched burst length
    logic [LEN_W-1:0]  issue_cnt; // accepted reads
    logic [LEN_W-1:0]  ret_cnt;   // returned beats
    logic              accept;

    assign mem_req.en   = (state == RDR_ISSUE);
    assign mem_req.addr = cur_addr; // held through stalls
    assign accept       = mem_req.en && mem_ready;

    assign fill.valid = mem_rvalid && (state != RDR_IDLE);
    assign fill.data  = mem_rdata;

    // address and length of the active burst
    always_ff @(posedge clk) begin
        if (state == RDR_IDLE && start) begin
            cur_addr <= burst.addr;
            len_q    <= burst.len;
        end else if (accept) begin
            cur_addr <= cur_addr + 1'b1; // consecutive words
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= RDR_IDLE;
            issue_cnt <= '0;
            ret_cnt   <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (fill.valid) begin
                ret_cnt <= ret_cnt + 1'b1;
            end
            case (state)
                RDR_IDLE: begin
                    if (start) begin
                        issue_cnt <= '0;
                        ret_cnt   <= '0;
                        state     <= RDR_ISSUE;
                    end
                end
                RDR_ISSUE: begin
                    if (accept) begin
                        issue_cnt <= issue_cnt + 1'b1;
                        if (issue_cnt == len_q) begin
                            state <= RDR_DRAIN; // all addresses out
                        end
                    end
                end
                RDR_DRAIN: begin
                    if (mem_rvalid && ret_cnt == len_q) begin
                        done  <= 1'b1; // last beat seen
                        state <= RDR_IDLE;
                    end
                end
                default: state <= RDR_IDLE;
            endcase
        end
    end

endmodule

// ==== hdl/mc_rd_top.sv ====
`timescale 1ns/100ps

module mc_rd_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  mc_rd_pkg::ch_cfg_t            cfg      [mc_rd_pkg::NUM_CH],
    input  logic [mc_rd_pkg::NUM_CH-1:0]  rd_en,
    output logic [mc_rd_pkg::DATA_W-1:0]  rd_data  [mc_rd_pkg::NUM_CH],
    output logic [mc_rd_pkg::NUM_CH-1:0]  rd_valid,
    output mc_rd_pkg::mem_req_t           mem_req,
    input  logic                          mem_ready,
    input  logic [mc_rd_pkg::DATA_W-1:0]  mem_rdata,
    input  logic                          mem_rvalid
);
    import mc_rd_pkg::*;

    ////////////////////////////////////////
    // interconnect
    ////////////////////////////////////////
    logic [NUM_CH-1:0] req;        // channel requests
    logic [NUM_CH-1:0] ack;        // per channel burst complete
    burst_t            burst [NUM_CH];
    logic [NUM_CH-1:0] fill_en;    // steered beat strobes
    logic [DATA_W-1:0] fill_data;
    logic              start;      // arbiter to reader
    burst_t            sel_burst;
    logic              done;       // reader to arbiter
    fill_t             fill;       // returned beat

    // one walker and fifo per channel
    for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
        rd_channel u_ch (
            .clk       (clk),
            .rst_n     (rst_n),
            .cfg       (cfg[i]),
            .rd_en     (rd_en[i]),
            .rd_data   (rd_data[i]),
            .rd_valid  (rd_valid[i]),
            .req       (req[i]),
            .burst     (burst[i]),
            .ack       (ack[i]),
            .fill_en   (fill_en[i]),
            .fill_data (fill_data)
        );
    end

    rd_arbiter u_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .burst     (burst),
        .ack       (ack),
        .start     (start),
        .sel_burst (sel_burst),
        .done      (done),
        .fill      (fill),
        .fill_en   (fill_en),
        .fill_data (fill_data)
    );

    burst_reader u_rdr (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .burst      (sel_burst),
        .done       (done),
        .mem_req    (mem_req),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata),
        .mem_rvalid (mem_rvalid),
        .fill       (fill)
    );

endmodule

// ==== dv/mc_rd_props.sv ====
`timescale 1ns/100ps

module mc_rd_props (
    input logic                         clk,
    input logic                         rst_n,
    input logic [mc_rd_pkg::NUM_CH-1:0] fill_en,
    input mc_rd_pkg::mem_req_t          mem_req,
    input logic                         mem_ready,
    input logic [mc_rd_pkg::NUM_CH-1:0] req,
    input logic [mc_rd_pkg::NUM_CH-1:0] ack
);
    import mc_rd_pkg::*;

    // a beat goes to one channel at most
    a_fill_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(fill_en))
        else $error("fill_en strobes more than one channel");

    // stalled read keeps its address
    a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.en && !mem_ready |=> mem_req.en && $stable(mem_req.addr))
        else $error("mem_req changed while stalled");

    for (genvar i = 0; i < NUM_CH; i++) begin : g_ack
        a_ack_release: assert property (@(posedge clk) disable iff (!rst_n)
            $fell(ack[i]) |-> !$past(req[i])) // falling half order
            else $error("ack %0d dropped while req still high", i);
    end

endmodule

bind mc_rd_top mc_rd_props i_props (.clk(clk), .rst_n(rst_n), .fill_en(fill_en),
    .mem_req(mem_req), .mem_ready(mem_ready), .req(req), .ack(ack));

// ==== dv/tb_mc_rd.sv ====
`timescale 1ns/100ps

module tb_mc_rd;
    import mc_rd_pkg::*;

    localparam int HOLD_CH = 3; // largest burst, 4 word tail at end_addr
    localparam logic [LEN_W-1:0] BLEN [NUM_CH] = '{8'd3, 8'd1, 8'd0, 8'd7};

    logic              clk;
    logic              rst_n;
    ch_cfg_t           cfg      [NUM_CH];
    logic [NUM_CH-1:0] rd_en;
    logic [DATA_W-1:0] rd_data  [NUM_CH];
    logic [NUM_CH-1:0] rd_valid;
    mem_req_t          mem_req;
    logic              mem_ready;
    logic [DATA_W-1:0] mem_rdata;
    logic              mem_rvalid;
    logic [31:0]       seed;              // lcg state
    logic              pend_valid;        // read taken at next posedge
    logic [ADDR_W-1:0] pend_addr;
    logic [ADDR_W-1:0] exp_addr [NUM_CH]; // reference walker per channel
    int                words    [NUM_CH]; // popped so far
    logic [NUM_CH-1:0] reading;           // channels allowed to pop

    mc_rd_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .rd_en      (rd_en),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid),
        .mem_req    (mem_req),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata),
        .mem_rvalid (mem_rvalid)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk; // 10 ns period
        end
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // memory contents, every address bit matters
    function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] a);
        return {a[1:0], a} ^ (32'(a) * 32'h0019_660d);
    endfunction

    function automatic logic in_some_range(input logic [ADDR_W-1:0] a);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < NUM_CH; i++) begin
            if (a >= cfg[i].beg_addr && a <= cfg[i].end_addr) hit = 1'b1;
        end
        return hit;
    endfunction

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic give_up(input string what);
        $display("Timeout at %0t ns: %s never happened", $time, what);
        $display("Simulation failed");
        $fatal(1, "timeout");
    endtask

    ////////////////////////////////////////
    // one cycle of memory model and user side
    ////////////////////////////////////////
    task automatic step();
        logic [31:0] r;
        @(negedge clk);
        r          = next_rand();
        mem_rvalid = pend_valid;                          // beat for last accept
        mem_rdata  = pend_valid ? mem_word(pend_addr) : '0;
        mem_ready  = (r[31:30] != 2'b00);                 // ready about 3/4
        pend_valid = mem_req.en && mem_ready;
        pend_addr  = mem_req.addr;
        if (pend_valid) begin
            check_eq(64'(in_some_range(pend_addr)), 64'd1, "read outside all ranges");
        end
        for (int i = 0; i < NUM_CH; i++) begin
            rd_en[i] = reading[i] && (r[2*i +: 2] != 2'b00);
            if (rd_en[i] && rd_valid[i]) begin // pops at next posedge
                check_eq(64'(rd_data[i]), 64'(mem_word(exp_addr[i])),
                         $sformatf("ch%0d word for addr %0h", i, exp_addr[i]));
                exp_addr[i] = (exp_addr[i] == cfg[i].end_addr) ? cfg[i].beg_addr
                                                               : exp_addr[i] + 1'b1;
                words[i]++;
            end
        end
    endtask

    // step until every masked channel pops target more words
    task automatic run_until(input logic [NUM_CH-1:0] mask, input int target,
                             input int limit, input string what);
        int   base [NUM_CH];
        int   cycles;
        logic met;
        base   = words;
        cycles = 0;
        met    = 1'b0;
        while (!met) begin
            if (cycles == limit) give_up(what);
            step();
            cycles++;
            met = 1'b1;
            for (int i = 0; i < NUM_CH; i++) begin
                if (mask[i] && words[i] - base[i] < target) met = 1'b0;
            end
        end
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////
    initial begin
        seed       = 32'h38dabdbf;
        rst_n      = 1'b0;
        rd_en      = '0;
        mem_ready  = 1'b0;
        mem_rdata  = '0;
        mem_rvalid = 1'b0;
        pend_valid = 1'b0;
        pend_addr  = '0;
        reading    = '0;
        for (int i = 0; i < NUM_CH; i++) begin
            cfg[i].beg_addr  = ADDR_W'(32'h1000 * (i + 1) + 24 * i); // unaligned starts
            cfg[i].end_addr  = cfg[i].beg_addr + ADDR_W'((i == 3) ? 99 : 127);
            cfg[i].burst_len = BLEN[i];
            exp_addr[i]      = cfg[i].beg_addr;
            words[i]         = 0;
        end
        repeat (16) step();
        rst_n = 1'b1; // released on a falling edge
        check_eq(64'(rd_valid), 64'd0, "rd_valid after reset");
        check_eq(64'(mem_req.en), 64'd0, "mem_req.en after reset");

        reading = '1; // all channels, random back-pressure
        run_until('1, 200, 40000, "200 words on every channel");

        reading = ~(NUM_CH'(1) << HOLD_CH); // park one consumer
        run_until(reading, 150, 40000, "other channels streaming past a stalled one");
        check_eq(64'(rd_valid[HOLD_CH]), 64'd1, "stalled channel holds data");

        reading = '1; // resume, stream must pick up where it stopped
        run_until('1, 100, 40000, "100 more words on every channel");

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== list.f ====
hdl/mc_rd_pkg.sv
hdl/chan_fifo.sv
hdl/rd_channel.sv
hdl/rd_arbiter.sv
hdl/burst_reader.sv
hdl/mc_rd_top.sv
dv/mc_rd_props.sv
dv/tb_mc_rd.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mc_rd -f list.f -o sim_mc_rd
./obj_dir/sim_mc_rd
